/* verilog/zxuno_pkg.sv */
package zxuno_pkg;

  // --------------------
  // I/O ports and register indices
  // --------------------

  // Register index port
  localparam logic [15:0] ADDR_PORT = 16'hFC3B;
  // Register data port
  localparam logic [15:0] DATA_PORT = 16'hFD3B;

  localparam logic [7:0] REG_COREID      = 8'hFF;
  localparam logic [7:0] REG_SCRATCH     = 8'hFE;
  localparam logic [7:0] REG_DEVOPTIONS  = 8'h0E;
  localparam logic [7:0] REG_SCANDBLCTRL = 8'h0B;

  // Core identification string, first character at index 0
  localparam int COREID_LEN = 5;
  localparam logic [0:COREID_LEN-1][7:0] COREID_TEXT = "ZXIO1";

  // Idle bus value, also the byte fed to the CPU on INT acknowledge
  localparam logic [7:0] FLOAT_BUS = 8'hFF;

  // Register values after reset
  localparam logic [7:0] SCANDBL_RESET = 8'h00;
  localparam logic [7:0] DEVOPT_RESET  = 8'h00;

  // --------------------
  // Bus types
  // --------------------

  // CPU side signals as seen by the I/O logic
  typedef struct packed {
    logic [15:0] a;
    logic [7:0]  dout;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
    logic        mreq_n;
  } cpu_bus_t;

  // Register file access, shared by every indexed register
  typedef struct packed {
    logic [7:0] addr;
    logic       regrd;
    logic       regwr;
    logic       regaddr_changed;
  } zxreg_t;

  // Device enable flags, bit 0 at the bottom of the list
  typedef struct packed {
    logic disable_spisd;
    logic enable_timexmmu;
    logic disable_romsel1f;
    logic disable_romsel7f;
    logic disable_1ffd;
    logic disable_7ffd;
    logic disable_turboay;
    logic disable_ay;
  } dev_enables_t;

  // Scandoubler control fields
  typedef struct packed {
    logic [1:0] cpu_speed;
    logic       csync_option;
    logic [2:0] freq_option;
    logic       scanlines_enable;
    logic       vga_enable;
  } scandbl_fields_t;

  // Same byte seen whole or split into fields
  typedef union packed {
    logic [7:0]      raw;
    scandbl_fields_t fields;
  } scandbl_u;

  // One read source towards the CPU data mux
  typedef struct packed {
    logic [7:0] data;
    logic       oe;
  } rd_src_t;

endpackage

/* verilog/zxuno_addr_reg.sv */
`timescale 1ns/1ps

module zxuno_addr_reg (
  input  logic                sysclk,
  input  logic                rst_n,
  input  zxuno_pkg::cpu_bus_t bus,
  output zxuno_pkg::zxreg_t   zxreg,
  output zxuno_pkg::rd_src_t  addr_rd
);

  // I/O cycle qualifiers
  logic io_wr;
  logic io_rd;
  // Port hits
  logic sel_addr;
  logic sel_data;
  // Write strobes and their delayed copies
  logic idx_wr;
  logic idx_wr_q;
  logic dat_wr;
  logic dat_wr_q;
  logic idx_wr_edge;
  // Current register index
  logic [7:0] index_q;
  logic addr_changed_q;

  // --------------------
  // Port decode
  // --------------------

  assign io_wr = !bus.iorq_n && !bus.wr_n;
  assign io_rd = !bus.iorq_n && !bus.rd_n;

  assign sel_addr = (bus.a == zxuno_pkg::ADDR_PORT);
  assign sel_data = (bus.a == zxuno_pkg::DATA_PORT);

  assign idx_wr = io_wr && sel_addr;
  assign dat_wr = io_wr && sel_data;

  // First cycle of an index write
  assign idx_wr_edge = idx_wr && !idx_wr_q;

  // --------------------
  // Index register
  // --------------------

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      idx_wr_q       <= 1'b0;
      dat_wr_q       <= 1'b0;
      index_q        <= 8'h00;
      addr_changed_q <= 1'b0;
    end else begin
      idx_wr_q <= idx_wr;
      dat_wr_q <= dat_wr;
      // One cycle flag, aligned with the new index
      addr_changed_q <= idx_wr_edge;
      if (idx_wr_edge) begin
        index_q <= bus.dout;
      end
    end
  end

  // --------------------
  // Register access strobes
  // --------------------

  assign zxreg.addr            = index_q;
  // Read strobe follows the CPU level
  assign zxreg.regrd           = io_rd && sel_data;
  // Write strobe only on the first cycle
  assign zxreg.regwr           = dat_wr && !dat_wr_q;
  assign zxreg.regaddr_changed = addr_changed_q;

  // Index readback on the address port
  assign addr_rd.data = index_q;
  assign addr_rd.oe   = io_rd && sel_addr;

  // No register sees a read and a write in the same cycle
  regrd_regwr_excl : assert property (
    @(posedge sysclk) disable iff (!rst_n) !(zxreg.regrd && zxreg.regwr)
  );

endmodule

/* verilog/coreid_reader.sv */
`timescale 1ns/1ps

module coreid_reader (
  input  logic               sysclk,
  input  logic               rst_n,
  input  zxuno_pkg::zxreg_t  zxreg,
  output zxuno_pkg::rd_src_t id_rd
);

  // Character pointer, COREID_LEN means past the end
  logic [2:0] ptr_q;
  // Read strobe on the ID register
  logic       id_read;
  logic       id_read_q;
  logic       ptr_valid;
  logic [7:0] id_char;

  assign id_read   = zxreg.regrd && (zxreg.addr == zxuno_pkg::REG_COREID);
  assign ptr_valid = (ptr_q < 3'(zxuno_pkg::COREID_LEN));

  // Zero byte once the text is exhausted
  assign id_char = ptr_valid ? zxuno_pkg::COREID_TEXT[ptr_q] : 8'h00;

  // --------------------
  // Pointer update
  // --------------------

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q     <= 3'd0;
      id_read_q <= 1'b0;
    end else begin
      id_read_q <= id_read;
      if (zxreg.regaddr_changed) begin
        // New index selects the start of the text
        ptr_q <= 3'd0;
      end else if (id_read_q && !id_read && ptr_valid) begin
        // Step after the strobe ends
        ptr_q <= ptr_q + 3'd1;
      end
    end
  end

  assign id_rd.data = id_char;
  assign id_rd.oe   = id_read;

  // Pointer parks at the end of the text
  ptr_in_range : assert property (
    @(posedge sysclk) disable iff (!rst_n) ptr_q <= 3'(zxuno_pkg::COREID_LEN)
  );

endmodule

/* verilog/option_regs.sv */
`timescale 1ns/1ps

module option_regs (
  input  logic                    sysclk,
  input  logic                    rst_n,
  input  zxuno_pkg::zxreg_t       zxreg,
  input  logic [7:0]              din,
  output zxuno_pkg::rd_src_t      scratch_rd,
  output zxuno_pkg::rd_src_t      devopt_rd,
  output zxuno_pkg::rd_src_t      scandbl_rd,
  output zxuno_pkg::dev_enables_t dev_enables,
  output zxuno_pkg::scandbl_u     scandbl
);

  // Index matches
  logic hit_scratch;
  logic hit_devopt;
  logic hit_scandbl;

  // Stored bytes
  logic [7:0]              scratch_q;
  zxuno_pkg::dev_enables_t devopt_q;
  zxuno_pkg::scandbl_u     scandbl_q;

  // --------------------
  // Index decode
  // --------------------

  assign hit_scratch = (zxreg.addr == zxuno_pkg::REG_SCRATCH);
  assign hit_devopt  = (zxreg.addr == zxuno_pkg::REG_DEVOPTIONS);
  assign hit_scandbl = (zxreg.addr == zxuno_pkg::REG_SCANDBLCTRL);

  // --------------------
  // Register write
  // --------------------

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      scratch_q     <= 8'h00;
      devopt_q      <= zxuno_pkg::dev_enables_t'(zxuno_pkg::DEVOPT_RESET);
      scandbl_q.raw <= zxuno_pkg::SCANDBL_RESET;
    end else if (zxreg.regwr) begin
      // Only the selected register takes the byte
      if (hit_scratch) begin
        scratch_q <= din;
      end
      if (hit_devopt) begin
        devopt_q <= zxuno_pkg::dev_enables_t'(din);
      end
      if (hit_scandbl) begin
        // Whole byte in, fields decoded by the union
        scandbl_q.raw <= din;
      end
    end
  end

  // --------------------
  // Readback
  // --------------------

  // Scratch byte, plain storage for software
  assign scratch_rd.data = scratch_q;
  assign scratch_rd.oe   = zxreg.regrd && hit_scratch;

  // Device options byte
  assign devopt_rd.data = devopt_q;
  assign devopt_rd.oe   = zxreg.regrd && hit_devopt;

  // Scandoubler control byte
  assign scandbl_rd.data = scandbl_q.raw;
  assign scandbl_rd.oe   = zxreg.regrd && hit_scandbl;

  // --------------------
  // Exported controls
  // --------------------

  // Device enables in register bit order
  assign dev_enables = devopt_q;

  // Video and CPU speed fields
  assign scandbl = scandbl_q;

endmodule

/* verilog/cpu_din_mux.sv */
`timescale 1ns/1ps

module cpu_din_mux (
  input  zxuno_pkg::cpu_bus_t bus,
  input  zxuno_pkg::rd_src_t  addr_rd,
  input  zxuno_pkg::rd_src_t  id_rd,
  input  zxuno_pkg::rd_src_t  scratch_rd,
  input  zxuno_pkg::rd_src_t  devopt_rd,
  input  zxuno_pkg::rd_src_t  scandbl_rd,
  output logic [7:0]          cpudin
);

  // Interrupt acknowledge cycle
  logic int_ack;
  // All register output enables
  logic [4:0] reg_oe;

  assign int_ack = !bus.iorq_n && !bus.m1_n;

  assign reg_oe = {addr_rd.oe, id_rd.oe, scratch_rd.oe, devopt_rd.oe, scandbl_rd.oe};

  // --------------------
  // Fixed priority select
  // --------------------

  always_comb begin
    case (1'b1)
      // Forced byte while the CPU fetches the vector
      int_ack       : cpudin = zxuno_pkg::FLOAT_BUS;
      addr_rd.oe    : cpudin = addr_rd.data;
      id_rd.oe      : cpudin = id_rd.data;
      scratch_rd.oe : cpudin = scratch_rd.data;
      devopt_rd.oe  : cpudin = devopt_rd.data;
      scandbl_rd.oe : cpudin = scandbl_rd.data;
      // Nobody drives the bus
      default       : cpudin = zxuno_pkg::FLOAT_BUS;
    endcase
  end

  // Register decoders never overlap, checked at the end of each read
  single_source : assert property (
    @(posedge bus.rd_n) $onehot0(reg_oe)
  );

endmodule

/* verilog/zxuno_io.sv */
`timescale 1ns/1ps

module zxuno_io (
  input  logic                    sysclk,
  input  logic                    rst_n,
  input  zxuno_pkg::cpu_bus_t     bus,
  output logic [7:0]              cpudin,
  output zxuno_pkg::dev_enables_t dev_enables,
  output zxuno_pkg::scandbl_u     scandbl
);

  // Register access bus
  zxuno_pkg::zxreg_t zxreg;

  // Read sources towards the CPU
  zxuno_pkg::rd_src_t addr_rd;
  zxuno_pkg::rd_src_t id_rd;
  zxuno_pkg::rd_src_t scratch_rd;
  zxuno_pkg::rd_src_t devopt_rd;
  zxuno_pkg::rd_src_t scandbl_rd;

  // --------------------
  // Index and strobes
  // --------------------

  zxuno_addr_reg addr_reg_i (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .bus     (bus),
    .zxreg   (zxreg),
    .addr_rd (addr_rd)
  );

  // --------------------
  // Registers
  // --------------------

  coreid_reader coreid_i (
    .sysclk (sysclk),
    .rst_n  (rst_n),
    .zxreg  (zxreg),
    .id_rd  (id_rd)
  );

  // Data from the CPU output bus
  option_regs option_regs_i (
    .sysclk      (sysclk),
    .rst_n       (rst_n),
    .zxreg       (zxreg),
    .din         (bus.dout),
    .scratch_rd  (scratch_rd),
    .devopt_rd   (devopt_rd),
    .scandbl_rd  (scandbl_rd),
    .dev_enables (dev_enables),
    .scandbl     (scandbl)
  );

  // --------------------
  // CPU input data
  // --------------------

  cpu_din_mux din_mux_i (
    .bus        (bus),
    .addr_rd    (addr_rd),
    .id_rd      (id_rd),
    .scratch_rd (scratch_rd),
    .devopt_rd  (devopt_rd),
    .scandbl_rd (scandbl_rd),
    .cpudin     (cpudin)
  );

endmodule

/* bench/zxuno_io_checker.sv */
`timescale 1ns/1ps

module zxuno_io_checker (
  input  logic                    sysclk,
  input  logic                    rst_n,
  input  zxuno_pkg::cpu_bus_t     bus,
  input  logic [7:0]              cpudin,
  input  zxuno_pkg::dev_enables_t dev_enables,
  input  zxuno_pkg::scandbl_u     scandbl,
  output int                      errors,
  output int                      checks
);

  // --------------------
  // Reference model state
  // --------------------

  logic [7:0] m_index;
  logic [7:0] m_scratch;
  logic [7:0] m_devopt;
  logic [7:0] m_scandbl;
  int         m_ptr;
  // Pulse one cycle after an index write
  logic       m_changed;
  // Previous cycle strobes for edge detection
  logic       m_prev_idx_wr;
  logic       m_prev_dat_wr;
  logic       m_prev_id_rd;

  // ID text, first character in the top byte
  function automatic logic [7:0] id_char(input int p);
    logic [39:0] text;
    text = "ZXIO1";
    if (p >= 5) begin
      return 8'h00;
    end
    return text[39 - 8*p -: 8];
  endfunction

  function automatic logic [7:0] data_port_value(input logic [7:0] idx);
    case (idx)
      8'hFF:   return id_char(m_ptr);
      8'hFE:   return m_scratch;
      8'h0E:   return m_devopt;
      8'h0B:   return m_scandbl;
      // Unused index floats
      default: return 8'hFF;
    endcase
  endfunction

  task automatic compare(input string what, input logic [7:0] got, input logic [7:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("MISMATCH at %0t: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  // --------------------
  // Compare and step on every rising edge
  // --------------------

  always @(posedge sysclk) begin : model_step
    logic io_wr;
    logic io_rd;
    logic int_ack;
    logic idx_wr;
    logic dat_wr;
    logic id_rd_now;
    logic [7:0] exp;
    if (!rst_n) begin
      m_index       = 8'h00;
      m_scratch     = 8'h00;
      m_devopt      = 8'h00;
      m_scandbl     = 8'h00;
      m_ptr         = 0;
      m_changed     = 1'b0;
      m_prev_idx_wr = 1'b0;
      m_prev_dat_wr = 1'b0;
      m_prev_id_rd  = 1'b0;
    end else begin
      io_wr     = !bus.iorq_n && !bus.wr_n;
      io_rd     = !bus.iorq_n && !bus.rd_n;
      int_ack   = !bus.iorq_n && !bus.m1_n;
      idx_wr    = io_wr && (bus.a == 16'hFC3B);
      dat_wr    = io_wr && (bus.a == 16'hFD3B);
      id_rd_now = io_rd && (bus.a == 16'hFD3B) && (m_index == 8'hFF);

      // Read data, int ack wins over everything
      if (io_rd || int_ack) begin
        if (int_ack) begin
          exp = 8'hFF;
        end else if (bus.a == 16'hFC3B) begin
          exp = m_index;
        end else if (bus.a == 16'hFD3B) begin
          exp = data_port_value(m_index);
        end else begin
          exp = 8'hFF;
        end
        compare($sformatf("cpudin port %04h index %02h", bus.a, m_index), cpudin, exp);
      end

      // Exported controls every cycle
      compare("dev_enables", dev_enables, m_devopt);
      compare("scandbl", scandbl.raw, m_scandbl);
      // Each named field on its documented bit
      compare("dev_enables fields",
              {dev_enables.disable_spisd, dev_enables.enable_timexmmu,
               dev_enables.disable_romsel1f, dev_enables.disable_romsel7f,
               dev_enables.disable_1ffd, dev_enables.disable_7ffd,
               dev_enables.disable_turboay, dev_enables.disable_ay},
              m_devopt);
      compare("scandbl fields",
              {scandbl.fields.cpu_speed, scandbl.fields.csync_option,
               scandbl.fields.freq_option, scandbl.fields.scanlines_enable,
               scandbl.fields.vga_enable},
              m_scandbl);

      // Pointer steps after the read ends, index change restarts it
      if (m_changed) begin
        m_ptr = 0;
      end else if (m_prev_id_rd && !id_rd_now && m_ptr < 5) begin
        m_ptr = m_ptr + 1;
      end
      m_changed    = idx_wr && !m_prev_idx_wr;
      m_prev_id_rd = id_rd_now;

      // Data write on the first strobe cycle, old index selects
      if (dat_wr && !m_prev_dat_wr) begin
        case (m_index)
          8'hFE:   m_scratch = bus.dout;
          8'h0E:   m_devopt  = bus.dout;
          8'h0B:   m_scandbl = bus.dout;
          default: ;
        endcase
      end
      if (idx_wr && !m_prev_idx_wr) begin
        m_index = bus.dout;
      end
      m_prev_idx_wr = idx_wr;
      m_prev_dat_wr = dat_wr;
    end
  end

endmodule

/* bench/tb_zxuno_io.sv */
`timescale 1ns/1ps

module tb_zxuno_io;

  localparam int CLK_PERIOD = 100;
  localparam int N_OPS      = 400;
  // Three cycles per access plus margin for reset and the directed part
  localparam int TIMEOUT_NS = N_OPS * 3 * CLK_PERIOD + 10000;

  logic                    sysclk;
  logic                    rst_n;
  zxuno_pkg::cpu_bus_t     bus;
  logic [7:0]              cpudin;
  zxuno_pkg::dev_enables_t dev_enables;
  zxuno_pkg::scandbl_u     scandbl;
  int                      errors;
  int                      checks;
  logic [31:0]             lfsr_state;

  zxuno_io dut_i (
    .sysclk      (sysclk),
    .rst_n       (rst_n),
    .bus         (bus),
    .cpudin      (cpudin),
    .dev_enables (dev_enables),
    .scandbl     (scandbl)
  );

  zxuno_io_checker checker_i (
    .sysclk      (sysclk),
    .rst_n       (rst_n),
    .bus         (bus),
    .cpudin      (cpudin),
    .dev_enables (dev_enables),
    .scandbl     (scandbl),
    .errors      (errors),
    .checks      (checks)
  );

  // --------------------
  // Random source
  // --------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // Mostly the four registers, now and then any byte
  function automatic logic [7:0] pick_index();
    logic [31:0] r;
    r = take_bits(3);
    case (r[2:0])
      3'd0, 3'd4: return zxuno_pkg::REG_COREID;
      3'd1:       return zxuno_pkg::REG_SCRATCH;
      3'd2, 3'd5: return zxuno_pkg::REG_DEVOPTIONS;
      3'd3, 3'd6: return zxuno_pkg::REG_SCANDBLCTRL;
      default: begin
        r = take_bits(8);
        return r[7:0];
      end
    endcase
  endfunction

  // --------------------
  // Bus access, called on a falling edge
  // --------------------

  task automatic io_access(input logic [15:0] a, input logic [7:0] d,
                           input logic rd, input logic wr, input logic m1);
    bus.a      = a;
    bus.dout   = d;
    bus.iorq_n = 1'b0;
    bus.rd_n   = !rd;
    bus.wr_n   = !wr;
    bus.m1_n   = !m1;
    repeat (2) @(negedge sysclk);
    bus.iorq_n = 1'b1;
    bus.rd_n   = 1'b1;
    bus.wr_n   = 1'b1;
    bus.m1_n   = 1'b1;
    @(negedge sysclk);
  endtask

  task automatic set_index(input logic [7:0] idx);
    io_access(zxuno_pkg::ADDR_PORT, idx, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic read_port(input logic [15:0] a);
    io_access(a, 8'h00, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic random_op();
    logic [31:0] r;
    logic [31:0] v;
    r = take_bits(3);
    v = take_bits(16);
    case (r[2:0])
      3'd0, 3'd1: set_index(pick_index());
      3'd2:       io_access(zxuno_pkg::DATA_PORT, v[7:0], 1'b0, 1'b1, 1'b0);
      3'd3, 3'd4: read_port(zxuno_pkg::DATA_PORT);
      3'd5:       read_port(zxuno_pkg::ADDR_PORT);
      3'd6: begin
        // Any port other than the two of the register file
        if (v[15:0] == zxuno_pkg::ADDR_PORT || v[15:0] == zxuno_pkg::DATA_PORT) begin
          v[0] = !v[0];
        end
        read_port(v[15:0]);
      end
      default:    io_access(v[15:0], 8'h00, 1'b0, 1'b0, 1'b1);
    endcase
  endtask

  initial begin
    sysclk = 1'b0;
    forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    lfsr_state  = 32'h3e0d3aec;
    rst_n       = 1'b0;
    bus.a       = 16'h0000;
    bus.dout    = 8'h00;
    bus.iorq_n  = 1'b1;
    bus.rd_n    = 1'b1;
    bus.wr_n    = 1'b1;
    bus.m1_n    = 1'b1;
    bus.mreq_n  = 1'b1;
    repeat (5) @(negedge sysclk);
    rst_n = 1'b1;
    @(negedge sysclk);

    // Reset values of the writable registers
    set_index(zxuno_pkg::REG_SCRATCH);
    read_port(zxuno_pkg::DATA_PORT);
    set_index(zxuno_pkg::REG_DEVOPTIONS);
    read_port(zxuno_pkg::DATA_PORT);
    set_index(zxuno_pkg::REG_SCANDBLCTRL);
    read_port(zxuno_pkg::DATA_PORT);

    // Whole ID text, the trailing zero, then a restart
    set_index(zxuno_pkg::REG_COREID);
    repeat (6) read_port(zxuno_pkg::DATA_PORT);
    set_index(zxuno_pkg::REG_COREID);
    read_port(zxuno_pkg::DATA_PORT);

    // Unused index reads as a floating bus
    set_index(8'h42);
    read_port(zxuno_pkg::DATA_PORT);

    read_port(zxuno_pkg::ADDR_PORT);
    io_access(16'h0038, 8'h00, 1'b0, 1'b0, 1'b1);
    read_port(16'h00FE);

    repeat (N_OPS) random_op();
    repeat (2) @(negedge sysclk);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* zxuno_io.f */
verilog/zxuno_pkg.sv
verilog/zxuno_addr_reg.sv
verilog/coreid_reader.sv
verilog/option_regs.sv
verilog/cpu_din_mux.sv
verilog/zxuno_io.sv
bench/zxuno_io_checker.sv
bench/tb_zxuno_io.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the ZX-Uno I/O register testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_zxuno_io -f zxuno_io.f \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
  echo "No pass line found in $LOG"
  exit 1
fi
exit 0
